//--- lua_pkg.sv
`default_nettype none

package lua_pkg;

	typedef logic [31:0] word_t;
	typedef logic [6:0] ttag_t;

	localparam ttag_t TT_INT = 7'd19; // compared on low five bits
	localparam int TVALUE_SHIFT = 3; // 8-byte stack slot
	localparam word_t SAVEDPC_OFS = 32'd20;

	typedef enum logic [1:0] {
		CMD_RUN = 2'd0,
		CMD_LOAD_REG = 2'd1,
		CMD_LOAD_TT = 2'd2,
		CMD_LOAD_BASE = 2'd3
	} cmd_e;

	typedef enum logic [5:0] {
		OP_MOVE = 6'd0,
		OP_ADD = 6'd13,
		OP_SUB = 6'd14,
		OP_MUL = 6'd15
	} opcode_e;

	typedef enum logic [1:0] {
		INSTR_IN_PROGRESS = 2'd0,
		INSTR_DONE = 2'd1,
		INSTR_IDLE = 2'd2,
		INSTR_NOT_IMPL = 2'd3
	} instr_status_e;

	typedef enum logic [1:0] {
		A_SRC_INSTR = 2'd0,
		A_SRC_DUMP = 2'd1,
		A_SRC_HOST = 2'd3
	} a_src_e;

	typedef enum logic [3:0] {
		ST_IDLE = 4'd0,
		ST_FETCH_PC = 4'd1,
		ST_FETCH_INSTR = 4'd2,
		ST_STORE_PC = 4'd3,
		ST_EXEC = 4'd4,
		ST_LOAD_REG = 4'd5,
		ST_LOAD_TT = 4'd6,
		ST_LOAD_BASE = 4'd7,
		ST_STORE_REGS = 4'd8,
		ST_FINISH = 4'd15
	} cmd_state_e;

	typedef enum logic [1:0] {
		PH_START = 2'd0,
		PH_DATA = 2'd1,
		PH_TYPE = 2'd2,
		PH_DONE = 2'd3
	} dump_phase_e;

endpackage

`default_nettype wire

//--- lua_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module lua_cmd_seq (
	input wire clk,
	input wire rst,
	input wire start,
	input wire lua_pkg::cmd_e cmd,
	input wire pc_done,
	input wire ir_done,
	input wire dump_done,
	input wire global_dirty,
	input wire lua_pkg::instr_status_e instr_status,
	output logic done,
	output logic fetch_pc,
	output logic store_pc,
	output logic fetch_instr,
	output logic incr_pc,
	output logic run_instr,
	output logic store_regs,
	output logic host_wr_data,
	output logic host_wr_type,
	output logic write_base,
	output logic clear_dirty,
	output logic clear_valid,
	output lua_pkg::a_src_e a_src
);
	import lua_pkg::*;

	cmd_state_e state;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						case (cmd)
							CMD_RUN: state <= ST_FETCH_PC;
							CMD_LOAD_REG: state <= ST_LOAD_REG;
							CMD_LOAD_TT: state <= ST_LOAD_TT;
							default: state <= ST_LOAD_BASE;
						endcase
					end
				end
				ST_FETCH_PC: begin
					if (pc_done)
						state <= ST_FETCH_INSTR;
				end
				ST_FETCH_INSTR: begin
					if (ir_done)
						state <= ST_EXEC;
				end
				ST_EXEC: begin
					case (instr_status)
						INSTR_DONE: state <= ST_FETCH_INSTR;
						INSTR_NOT_IMPL: state <= ST_STORE_PC; // first op we can't run
						default: state <= ST_EXEC;
					endcase
				end
				ST_STORE_PC: begin
					if (pc_done)
						state <= global_dirty ? ST_STORE_REGS : ST_FINISH;
				end
				ST_STORE_REGS: begin
					if (dump_done)
						state <= ST_FINISH;
				end
				ST_LOAD_REG, ST_LOAD_TT, ST_LOAD_BASE: state <= ST_FINISH;
				default: state <= ST_IDLE; // FINISH and unused codes
			endcase
		end
	end

	always_comb begin
		done = 1'b0;
		fetch_pc = 1'b0;
		store_pc = 1'b0;
		fetch_instr = 1'b0;
		incr_pc = 1'b0;
		run_instr = 1'b0;
		store_regs = 1'b0;
		host_wr_data = 1'b0;
		host_wr_type = 1'b0;
		write_base = 1'b0;
		clear_dirty = 1'b0;
		clear_valid = 1'b0;
		a_src = A_SRC_INSTR;
		case (state)
			ST_FETCH_PC: fetch_pc = 1'b1;
			ST_FETCH_INSTR: begin
				fetch_instr = 1'b1;
				incr_pc = ir_done; // step pc as the fetch retires
			end
			ST_EXEC: run_instr = 1'b1;
			ST_STORE_PC: store_pc = 1'b1;
			ST_STORE_REGS: begin
				store_regs = 1'b1;
				a_src = A_SRC_DUMP;
			end
			ST_LOAD_REG: begin
				host_wr_data = 1'b1;
				a_src = A_SRC_HOST;
			end
			ST_LOAD_TT: begin
				host_wr_type = 1'b1;
				a_src = A_SRC_HOST;
			end
			ST_LOAD_BASE: begin
				// new frame, old register contents are meaningless
				write_base = 1'b1;
				clear_dirty = 1'b1;
				clear_valid = 1'b1;
			end
			ST_FINISH: begin
				done = 1'b1;
				clear_dirty = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- lua_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module lua_fetch (
	input wire clk,
	input wire rst,
	input wire fetch_pc,
	input wire store_pc,
	input wire fetch_instr,
	input wire incr_pc,
	input wire lua_pkg::word_t ci,
	input wire lua_pkg::word_t mem_readdata,
	input wire mem_waitrequest,
	output lua_pkg::word_t instruction,
	output logic pc_done,
	output logic ir_done,
	output lua_pkg::word_t mem_address,
	output lua_pkg::word_t mem_writedata,
	output logic mem_read,
	output logic mem_write
);
	import lua_pkg::*;

	word_t pc;
	logic pc_rd_req;
	logic pc_wr_req;
	logic ir_req;

	// requests drop in the done cycle so an access is never repeated
	assign pc_rd_req = fetch_pc && !pc_done;
	assign pc_wr_req = store_pc && !pc_done;
	assign ir_req = fetch_instr && !ir_done;

	always_comb begin
		mem_address = '0;
		mem_writedata = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		if (pc_rd_req || pc_wr_req) begin
			mem_address = ci + SAVEDPC_OFS; // savedpc in call-info
			mem_read = pc_rd_req;
			mem_write = pc_wr_req;
			mem_writedata = pc_wr_req ? pc : '0;
		end else if (ir_req) begin
			mem_address = pc;
			mem_read = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
			pc_done <= 1'b0;
			ir_done <= 1'b0;
		end else begin
			pc_done <= (pc_rd_req || pc_wr_req) && !mem_waitrequest;
			ir_done <= ir_req && !mem_waitrequest;
			if (pc_rd_req && !mem_waitrequest)
				pc <= mem_readdata;
			else if (incr_pc)
				pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (ir_req && !mem_waitrequest)
			instruction <= mem_readdata;
	end

endmodule

`default_nettype wire

//--- lua_exec.sv
`timescale 1ns/1ps
`default_nettype none

module lua_exec #(
	parameter int REG_ADDR_BITS = 6
) (
	input wire clk,
	input wire rst,
	input wire run_instr,
	input wire lua_pkg::word_t instruction,
	input wire lua_pkg::word_t data_b,
	input wire lua_pkg::word_t data_c,
	input wire lua_pkg::ttag_t type_b,
	input wire lua_pkg::ttag_t type_c,
	output logic [REG_ADDR_BITS-1:0] idx_a,
	output logic [REG_ADDR_BITS-1:0] idx_b,
	output logic [REG_ADDR_BITS-1:0] idx_c,
	output lua_pkg::word_t instr_wr_data,
	output lua_pkg::ttag_t instr_wr_type,
	output logic instr_wr_en,
	output lua_pkg::instr_status_e instr_status
);
	import lua_pkg::*;

	opcode_e opcode;
	logic k_b;
	logic k_c;
	logic int_ok;

	// op[5:0] a[13:6] c[22:14] b[31:23], top bit of b/c flags a constant
	assign opcode = opcode_e'(instruction[5:0]);
	assign idx_a = instruction[6 +: REG_ADDR_BITS];
	assign idx_c = instruction[14 +: REG_ADDR_BITS];
	assign idx_b = instruction[23 +: REG_ADDR_BITS];
	assign k_c = instruction[22];
	assign k_b = instruction[31];

	assign int_ok = (type_b[4:0] == TT_INT[4:0]) && (type_c[4:0] == TT_INT[4:0]) &&
		!k_b && !k_c;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instr_status <= INSTR_IDLE;
		end else if (!run_instr) begin
			instr_status <= INSTR_IDLE;
		end else begin
			case (instr_status)
				INSTR_IDLE: begin
					case (opcode)
						OP_MOVE: instr_status <= INSTR_IN_PROGRESS;
						OP_ADD, OP_SUB, OP_MUL:
							instr_status <= int_ok ? INSTR_IN_PROGRESS : INSTR_NOT_IMPL;
						default: instr_status <= INSTR_NOT_IMPL;
					endcase
				end
				INSTR_IN_PROGRESS: instr_status <= INSTR_DONE;
				default: instr_status <= INSTR_IDLE;
			endcase
		end
	end

	always_comb begin
		instr_wr_data = data_b;
		instr_wr_type = TT_INT;
		case (opcode)
			OP_ADD: instr_wr_data = data_b + data_c; // wraps at 32 bits
			OP_SUB: instr_wr_data = data_b - data_c;
			OP_MUL: instr_wr_data = data_b * data_c;
			default: instr_wr_type = type_b; // move keeps tag
		endcase
	end

	assign instr_wr_en = (instr_status == INSTR_IN_PROGRESS);

endmodule

`default_nettype wire

//--- lua_frame.sv
`timescale 1ns/1ps
`default_nettype none

module lua_frame #(
	parameter int REG_ADDR_BITS = 6
) (
	input wire clk,
	input wire rst,
	input wire write_base,
	input wire lua_pkg::word_t dataa,
	output lua_pkg::word_t base,
	output logic [REG_ADDR_BITS-1:0] host_idx,
	output logic host_idx_ok
);
	import lua_pkg::*;

	word_t slot_ofs;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			base <= '0;
		else if (write_base)
			base <= dataa;
	end

	assign slot_ofs = (dataa - base) >> TVALUE_SHIFT; // below base wraps high
	assign host_idx = slot_ofs[REG_ADDR_BITS-1:0];
	assign host_idx_ok = (slot_ofs[31:REG_ADDR_BITS] == '0);

endmodule

`default_nettype wire

//--- lua_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module lua_reg_file #(
	parameter int REG_ADDR_BITS = 6
) (
	input wire clk,
	input wire rst,
	input wire lua_pkg::a_src_e a_src,
	input wire [REG_ADDR_BITS-1:0] idx_a_instr,
	input wire [REG_ADDR_BITS-1:0] idx_a_dump,
	input wire [REG_ADDR_BITS-1:0] host_idx,
	input wire host_idx_ok,
	input wire [REG_ADDR_BITS-1:0] idx_b,
	input wire [REG_ADDR_BITS-1:0] idx_c,
	input wire lua_pkg::word_t instr_wr_data,
	input wire lua_pkg::ttag_t instr_wr_type,
	input wire instr_wr_en,
	input wire host_wr_data,
	input wire host_wr_type,
	input wire lua_pkg::word_t datab,
	input wire clear_dirty,
	input wire clear_valid,
	output lua_pkg::word_t data_a,
	output lua_pkg::ttag_t type_a,
	output logic dirty_a,
	output logic valid_a,
	output lua_pkg::word_t data_b,
	output lua_pkg::word_t data_c,
	output lua_pkg::ttag_t type_b,
	output lua_pkg::ttag_t type_c,
	output logic global_dirty
);
	import lua_pkg::*;

	localparam int REG_COUNT = 1 << REG_ADDR_BITS;

	word_t regs [REG_COUNT];
	ttag_t ttags [REG_COUNT];
	logic [REG_COUNT-1:0] dirty;
	logic [REG_COUNT-1:0] valid;
	logic [REG_ADDR_BITS-1:0] idx_a;
	logic instr_we;
	logic host_we;
	logic data_we;
	logic type_we;
	word_t wr_data;
	ttag_t wr_type;

	always_comb begin
		case (a_src)
			A_SRC_DUMP: idx_a = idx_a_dump;
			A_SRC_HOST: idx_a = host_idx;
			default: idx_a = idx_a_instr;
		endcase
	end

	assign instr_we = (a_src == A_SRC_INSTR) && instr_wr_en;
	assign host_we = (a_src == A_SRC_HOST) && host_idx_ok; // drop slots outside frame
	assign data_we = instr_we || (host_we && host_wr_data);
	assign type_we = instr_we || (host_we && host_wr_type);
	assign wr_data = host_we ? datab : instr_wr_data;
	assign wr_type = host_we ? datab[6:0] : instr_wr_type;

	always_ff @(posedge clk) begin
		if (data_we)
			regs[idx_a] <= wr_data;
		if (type_we)
			ttags[idx_a] <= wr_type;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dirty <= '0;
			valid <= '0;
			global_dirty <= 1'b0;
		end else if (clear_dirty || clear_valid) begin
			if (clear_dirty) begin
				dirty <= '0;
				global_dirty <= 1'b0;
			end
			if (clear_valid)
				valid <= '0;
		end else begin
			if (data_we || type_we)
				valid[idx_a] <= 1'b1;
			if (instr_we) begin // host loads stay clean
				dirty[idx_a] <= 1'b1;
				global_dirty <= 1'b1;
			end
		end
	end

	assign data_a = regs[idx_a];
	assign type_a = ttags[idx_a];
	assign dirty_a = dirty[idx_a];
	assign valid_a = valid[idx_a];
	assign data_b = regs[idx_b];
	assign data_c = regs[idx_c];
	assign type_b = ttags[idx_b];
	assign type_c = ttags[idx_c];

endmodule

`default_nettype wire

//--- lua_reg_dump.sv
`timescale 1ns/1ps
`default_nettype none

module lua_reg_dump #(
	parameter int REG_ADDR_BITS = 6
) (
	input wire clk,
	input wire rst,
	input wire store_regs,
	input wire lua_pkg::word_t base,
	input wire lua_pkg::word_t data_a,
	input wire lua_pkg::ttag_t type_a,
	input wire dirty_a,
	input wire valid_a,
	input wire mem_waitrequest,
	output logic [REG_ADDR_BITS-1:0] idx_a_dump,
	output logic dump_done,
	output lua_pkg::word_t mem_address,
	output lua_pkg::word_t mem_writedata,
	output logic mem_write
);
	import lua_pkg::*;

	dump_phase_e phase;
	logic [REG_ADDR_BITS-1:0] cur_reg;
	logic should_write;
	logic last_reg;
	word_t slot_addr;

	assign should_write = dirty_a && valid_a;
	assign last_reg = &cur_reg;
	assign slot_addr = base + (word_t'(cur_reg) << TVALUE_SHIFT);
	assign idx_a_dump = cur_reg;
	assign dump_done = (phase == PH_DONE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= PH_START;
			cur_reg <= '0;
		end else begin
			case (phase)
				PH_START: begin
					if (store_regs) begin
						cur_reg <= '0;
						phase <= PH_DATA;
					end
				end
				PH_DATA: begin
					if (!should_write) begin // clean, one cycle
						if (last_reg)
							phase <= PH_DONE;
						else
							cur_reg <= cur_reg + 1'b1;
					end else if (!mem_waitrequest) begin
						phase <= PH_TYPE;
					end
				end
				PH_TYPE: begin
					if (!mem_waitrequest) begin
						phase <= last_reg ? PH_DONE : PH_DATA;
						cur_reg <= cur_reg + 1'b1;
					end
				end
				default: phase <= PH_START;
			endcase
		end
	end

	always_comb begin
		mem_address = '0;
		mem_writedata = '0;
		mem_write = 1'b0;
		if (phase == PH_DATA && should_write) begin
			mem_address = slot_addr;
			mem_writedata = data_a;
			mem_write = 1'b1;
		end else if (phase == PH_TYPE) begin
			mem_address = slot_addr + 32'd4; // tag word of the slot
			mem_writedata = word_t'(type_a);
			mem_write = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- lua_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module lua_cpu #(
	parameter int REG_ADDR_BITS = 6
) (
	input wire clk,
	input wire rst,
	input wire start,
	input wire lua_pkg::cmd_e cmd,
	input wire lua_pkg::word_t dataa,
	input wire lua_pkg::word_t datab,
	output logic done,
	output lua_pkg::word_t mem_address,
	output lua_pkg::word_t mem_writedata,
	input wire lua_pkg::word_t mem_readdata,
	output logic mem_read,
	output logic mem_write,
	input wire mem_waitrequest
);
	import lua_pkg::*;

	logic fetch_pc, store_pc, fetch_instr, incr_pc, run_instr, store_regs;
	logic host_wr_data, host_wr_type, write_base, clear_dirty, clear_valid;
	logic pc_done, ir_done, dump_done, global_dirty;
	a_src_e a_src;
	instr_status_e instr_status;
	word_t instruction, base;
	logic [REG_ADDR_BITS-1:0] idx_a_instr, idx_b, idx_c, idx_a_dump, host_idx;
	logic host_idx_ok;
	word_t instr_wr_data, data_a, data_b, data_c;
	ttag_t instr_wr_type, type_a, type_b, type_c;
	logic instr_wr_en, dirty_a, valid_a;
	word_t fetch_address, fetch_writedata, dump_address, dump_writedata;
	logic fetch_read, fetch_write, dump_write;

	lua_cmd_seq i_seq (
		.clk(clk), .rst(rst), .start(start), .cmd(cmd),
		.pc_done(pc_done), .ir_done(ir_done), .dump_done(dump_done),
		.global_dirty(global_dirty), .instr_status(instr_status),
		.done(done), .fetch_pc(fetch_pc), .store_pc(store_pc),
		.fetch_instr(fetch_instr), .incr_pc(incr_pc), .run_instr(run_instr),
		.store_regs(store_regs), .host_wr_data(host_wr_data), .host_wr_type(host_wr_type),
		.write_base(write_base), .clear_dirty(clear_dirty), .clear_valid(clear_valid),
		.a_src(a_src)
	);

	lua_fetch i_fetch (
		.clk(clk), .rst(rst), .fetch_pc(fetch_pc), .store_pc(store_pc),
		.fetch_instr(fetch_instr), .incr_pc(incr_pc), .ci(datab), // call-info on datab
		.mem_readdata(mem_readdata), .mem_waitrequest(mem_waitrequest),
		.instruction(instruction), .pc_done(pc_done), .ir_done(ir_done),
		.mem_address(fetch_address), .mem_writedata(fetch_writedata),
		.mem_read(fetch_read), .mem_write(fetch_write)
	);

	lua_exec #(.REG_ADDR_BITS(REG_ADDR_BITS)) i_exec (
		.clk(clk), .rst(rst), .run_instr(run_instr), .instruction(instruction),
		.data_b(data_b), .data_c(data_c), .type_b(type_b), .type_c(type_c),
		.idx_a(idx_a_instr), .idx_b(idx_b), .idx_c(idx_c),
		.instr_wr_data(instr_wr_data), .instr_wr_type(instr_wr_type),
		.instr_wr_en(instr_wr_en), .instr_status(instr_status)
	);

	lua_frame #(.REG_ADDR_BITS(REG_ADDR_BITS)) i_frame (
		.clk(clk), .rst(rst), .write_base(write_base), .dataa(dataa),
		.base(base), .host_idx(host_idx), .host_idx_ok(host_idx_ok)
	);

	lua_reg_file #(.REG_ADDR_BITS(REG_ADDR_BITS)) i_reg_file (
		.clk(clk), .rst(rst), .a_src(a_src), .idx_a_instr(idx_a_instr),
		.idx_a_dump(idx_a_dump), .host_idx(host_idx), .host_idx_ok(host_idx_ok),
		.idx_b(idx_b), .idx_c(idx_c), .instr_wr_data(instr_wr_data),
		.instr_wr_type(instr_wr_type), .instr_wr_en(instr_wr_en),
		.host_wr_data(host_wr_data), .host_wr_type(host_wr_type), .datab(datab),
		.clear_dirty(clear_dirty), .clear_valid(clear_valid),
		.data_a(data_a), .type_a(type_a), .dirty_a(dirty_a), .valid_a(valid_a),
		.data_b(data_b), .data_c(data_c), .type_b(type_b), .type_c(type_c),
		.global_dirty(global_dirty)
	);

	lua_reg_dump #(.REG_ADDR_BITS(REG_ADDR_BITS)) i_reg_dump (
		.clk(clk), .rst(rst), .store_regs(store_regs), .base(base),
		.data_a(data_a), .type_a(type_a), .dirty_a(dirty_a), .valid_a(valid_a),
		.mem_waitrequest(mem_waitrequest), .idx_a_dump(idx_a_dump),
		.dump_done(dump_done), .mem_address(dump_address),
		.mem_writedata(dump_writedata), .mem_write(dump_write)
	);

	// idle units drive zero, only one is active per sequencer state
	assign mem_address = fetch_address | dump_address;
	assign mem_writedata = fetch_writedata | dump_writedata;
	assign mem_read = fetch_read;
	assign mem_write = fetch_write | dump_write;

endmodule

`default_nettype wire

//--- lua_cpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module lua_cpu_chk (
	input wire clk,
	input wire rst,
	input wire done,
	input wire mem_read,
	input wire mem_write,
	input wire mem_waitrequest,
	input wire lua_pkg::word_t mem_address,
	input wire lua_pkg::word_t mem_writedata
);
	int fail_count = 0;

	a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write))
	else begin
		$error("mem_read and mem_write high together");
		fail_count = fail_count + 1;
	end

	// stalled request keeps address, strobe and write data
	a_req_stable: assert property (@(posedge clk) disable iff (rst)
		(mem_read || mem_write) && mem_waitrequest |=>
			$stable(mem_address) && $stable(mem_read) && $stable(mem_write) &&
			(!mem_write || $stable(mem_writedata)))
	else begin
		$error("memory request changed under waitrequest");
		fail_count = fail_count + 1;
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
	else begin
		$error("done high for more than one cycle");
		fail_count = fail_count + 1;
	end

	a_done_after_rst: assert property (@(posedge clk) $fell(rst) |-> !done)
	else begin
		$error("done high right after reset");
		fail_count = fail_count + 1;
	end

endmodule

bind lua_cpu lua_cpu_chk i_chk (
	.clk(clk), .rst(rst), .done(done), .mem_read(mem_read), .mem_write(mem_write),
	.mem_waitrequest(mem_waitrequest), .mem_address(mem_address),
	.mem_writedata(mem_writedata)
);

`default_nettype wire

//--- tb_lua_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lua_cpu;
	import lua_pkg::*;

	localparam int REG_ADDR_BITS = 6;
	localparam int CYCLE_LIMIT = 20000; // six tests of under 200 accesses each with stalls
	localparam word_t CI_ADDR = 32'h0000_0100;
	localparam word_t BASE = 32'h0000_0800;
	localparam logic [5:0] OP_UNSUP = 6'd30;

	logic clk;
	logic rst;
	logic start;
	cmd_e cmd;
	word_t dataa;
	word_t datab;
	logic done;
	word_t mem_address;
	word_t mem_writedata;
	word_t mem_readdata;
	logic mem_read;
	logic mem_write;
	logic mem_waitrequest;

	word_t mem [0:1023];
	word_t wr_addr_q [$];
	word_t wr_data_q [$];
	int read_count = 0;
	int cycle_count = 0;
	integer seed;
	logic random_wait;

	lua_cpu #(.REG_ADDR_BITS(REG_ADDR_BITS)) i_dut (
		.clk(clk), .rst(rst), .start(start), .cmd(cmd), .dataa(dataa), .datab(datab),
		.done(done), .mem_address(mem_address), .mem_writedata(mem_writedata),
		.mem_readdata(mem_readdata), .mem_read(mem_read), .mem_write(mem_write),
		.mem_waitrequest(mem_waitrequest)
	);

	always #50 clk = ~clk;

	assign mem_readdata = mem[mem_address[11:2]]; // valid while the address is held

	task automatic poke(input word_t addr, input word_t data);
		mem[addr[11:2]] = data;
	endtask

	function automatic word_t peek(input word_t addr);
		return mem[addr[11:2]];
	endfunction

	always @(posedge clk) begin
		if ((mem_read || mem_write) && (mem_address[31:12] != '0 || mem_address[1:0] != '0)) begin
			$display("memory access outside the model at address %h", mem_address);
			$display("Test FAILED");
			$fatal(1);
		end else begin
			if (mem_read && !mem_waitrequest)
				read_count = read_count + 1;
			if (mem_write && !mem_waitrequest) begin
				poke(mem_address, mem_writedata);
				wr_addr_q.push_back(mem_address);
				wr_data_q.push_back(mem_writedata);
			end
			if (random_wait)
				mem_waitrequest <= ($random(seed) & 1) != 0;
			else
				mem_waitrequest <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (i_dut.i_chk.fail_count != 0) begin
			$display("a handshake assertion failed");
			$display("Test FAILED");
			$fatal(1);
		end else if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: done never arrived");
			$display("Test FAILED");
			$fatal(1);
		end else begin
			cycle_count <= cycle_count + 1;
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_ttag(input string name, input ttag_t got, input ttag_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// fields op[5:0] a[13:6] c[22:14] b[31:23]
	// top bit of b and c marks a constant
	function automatic word_t encode(input logic [5:0] op, input int a, input int b,
		input int c, input bit kb, input bit kc);
		return {kb, b[7:0], kc, c[7:0], a[7:0], op};
	endfunction

	function automatic word_t slot_addr(input int idx);
		return BASE + word_t'(idx) * 8;
	endfunction

	task automatic set_entry(input word_t pc0);
		poke(CI_ADDR + SAVEDPC_OFS, pc0);
	endtask

	task automatic check_write(input int n, input word_t addr, input word_t data);
		if (n >= wr_addr_q.size()) begin
			$display("memory write number %0d never happened", n);
			$display("Test FAILED");
			$fatal(1);
		end else begin
			check_word("mem_address", wr_addr_q[n], addr);
			check_word("mem_writedata", wr_data_q[n], data);
		end
	endtask

	task automatic check_slot(input int n, input int idx, input word_t val, input ttag_t tag);
		word_t addr;
		addr = slot_addr(idx);
		check_write(n, addr, val);
		check_write(n + 1, addr + 4, word_t'(tag)); // tag zero-extended
		check_word("slot data in memory", peek(addr), val);
		check_ttag("slot tag in memory", ttag_t'(peek(addr + 4)), tag);
	endtask

	task automatic issue_cmd(input cmd_e c, input word_t a, input word_t b, output int edges);
		@(posedge clk);
		start <= 1'b1;
		cmd <= c;
		dataa <= a;
		datab <= b;
		edges = 0;
		while (edges == 0 || !done) begin
			@(posedge clk);
			start <= 1'b0;
			edges = edges + 1;
			@(negedge clk);
		end
	endtask

	task automatic issue_load(input cmd_e c, input word_t a, input word_t b);
		int edges;
		int reads_before;
		int writes_before;
		reads_before = read_count;
		writes_before = wr_addr_q.size();
		issue_cmd(c, a, b, edges);
		check_count("done latency in edges", edges, 2);
		check_count("mem reads during load", read_count - reads_before, 0);
		check_count("mem writes during load", wr_addr_q.size() - writes_before, 0);
	endtask

	task automatic cmd_load_base(input word_t b);
		issue_load(CMD_LOAD_BASE, b, '0);
	endtask

	task automatic cmd_load_reg(input word_t addr, input word_t val);
		issue_load(CMD_LOAD_REG, addr, val);
	endtask

	task automatic cmd_load_tt(input word_t addr, input ttag_t tag);
		issue_load(CMD_LOAD_TT, addr, word_t'(tag));
	endtask

	task automatic cmd_run(input word_t ci, input word_t exp_pc, input int exp_writes);
		int edges;
		wr_addr_q.delete();
		wr_data_q.delete();
		issue_cmd(CMD_RUN, '0, ci, edges);
		check_count("mem write count", wr_addr_q.size(), exp_writes);
		check_write(0, ci + SAVEDPC_OFS, exp_pc); // pc store comes first
		check_word("saved pc in memory", peek(ci + SAVEDPC_OFS), exp_pc);
	endtask

	task automatic test_arith(input logic stall);
		word_t x;
		word_t y;
		word_t pc0;
		x = 32'hfedc_ba98;
		y = 32'h1234_5679;
		pc0 = 32'h0000_0200;
		random_wait = stall;
		poke(pc0, encode(OP_ADD, 3, 1, 2, 1'b0, 1'b0));
		poke(pc0 + 4, encode(OP_SUB, 4, 1, 2, 1'b0, 1'b0));
		poke(pc0 + 8, encode(OP_MUL, 5, 1, 2, 1'b0, 1'b0));
		poke(pc0 + 12, encode(OP_UNSUP, 0, 0, 0, 1'b0, 1'b0));
		set_entry(pc0);
		cmd_load_base(BASE);
		cmd_load_reg(slot_addr(1), x);
		cmd_load_tt(slot_addr(1), TT_INT);
		cmd_load_reg(slot_addr(2), y);
		cmd_load_tt(slot_addr(2), TT_INT);
		cmd_run(CI_ADDR, pc0 + 16, 7);
		check_slot(1, 3, x + y, TT_INT);
		check_slot(3, 4, x - y, TT_INT);
		check_slot(5, 5, x * y, TT_INT); // low 32 bits only
	endtask

	task automatic test_move();
		word_t pc0;
		pc0 = 32'h0000_0240;
		poke(pc0, encode(OP_MOVE, 7, 6, 0, 1'b0, 1'b0));
		poke(pc0 + 4, encode(OP_UNSUP, 0, 0, 0, 1'b0, 1'b0));
		set_entry(pc0);
		cmd_load_reg(slot_addr(6), 32'h0bad_cafe);
		cmd_load_tt(slot_addr(6), 7'h45);
		cmd_run(CI_ADDR, pc0 + 8, 3); // host-loaded reg 6 stays out of the dump
		check_slot(1, 7, 32'h0bad_cafe, 7'h45);
	endtask

	task automatic test_not_impl();
		word_t pc0;
		pc0 = 32'h0000_0280;
		poke(pc0, encode(OP_ADD, 8, 1, 2, 1'b0, 1'b0));
		poke(pc0 + 4, encode(OP_ADD, 8, 1, 2, 1'b0, 1'b1));
		poke(pc0 + 8, encode(OP_ADD, 8, 1, 2, 1'b1, 1'b0));
		set_entry(pc0);
		cmd_load_tt(slot_addr(1), 7'd3); // not an integer
		cmd_run(CI_ADDR, pc0 + 4, 1);
		cmd_load_tt(slot_addr(1), TT_INT);
		set_entry(pc0 + 4); // constant C
		cmd_run(CI_ADDR, pc0 + 8, 1);
		set_entry(pc0 + 8); // constant B
		cmd_run(CI_ADDR, pc0 + 12, 1);
	endtask

	task automatic test_clean_rerun();
		word_t pc0;
		pc0 = 32'h0000_02c0;
		poke(pc0, encode(OP_UNSUP, 0, 0, 0, 1'b0, 1'b0));
		set_entry(pc0);
		cmd_run(CI_ADDR, pc0 + 4, 1);
		random_wait = 1'b0;
	endtask

	task automatic test_out_of_range();
		word_t pc0;
		pc0 = 32'h0000_0300;
		poke(pc0, encode(OP_MOVE, 9, 0, 0, 1'b0, 1'b0));
		poke(pc0 + 4, encode(OP_UNSUP, 0, 0, 0, 1'b0, 1'b0));
		set_entry(pc0);
		cmd_load_reg(slot_addr(0), 32'h1357_9bdf);
		cmd_load_tt(slot_addr(0), 7'h2a);
		// one slot past the frame aliases index 0
		cmd_load_reg(slot_addr(1 << REG_ADDR_BITS), 32'hdead_beef);
		cmd_load_tt(slot_addr(1 << REG_ADDR_BITS), 7'h11);
		cmd_run(CI_ADDR, pc0 + 8, 3);
		check_slot(1, 9, 32'h1357_9bdf, 7'h2a);
	endtask

	initial begin
		int i;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		cmd = CMD_RUN;
		dataa = '0;
		datab = '0;
		mem_waitrequest = 1'b0;
		random_wait = 1'b0;
		seed = 32'h7ac3_bc0d;
		for (i = 0; i < 1024; i++)
			mem[i] = ~(word_t'(i) << 2); // inverted byte address
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		test_arith(1'b0);
		test_move();
		test_not_impl();
		test_arith(1'b1);
		test_clean_rerun();
		test_out_of_range();
		repeat (2) @(negedge clk);
		if (i_dut.i_chk.fail_count != 0) begin
			$display("handshake assertions failed %0d times", i_dut.i_chk.fail_count);
			$display("Test FAILED");
			$fatal(1);
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- build.f
lua_pkg.sv
lua_cmd_seq.sv
lua_fetch.sv
lua_exec.sv
lua_frame.sv
lua_reg_file.sv
lua_reg_dump.sv
lua_cpu.sv
lua_cpu_chk.sv
tb_lua_cpu.sv

//--- Bender.yml
package:
  name: lua_cpu

sources:
  - lua_pkg.sv
  - lua_cmd_seq.sv
  - lua_fetch.sv
  - lua_exec.sv
  - lua_frame.sv
  - lua_reg_file.sv
  - lua_reg_dump.sv
  - lua_cpu.sv
  - target: test
    files:
      - lua_cpu_chk.sv
      - tb_lua_cpu.sv
